/* verilog/apu_pkg.sv */
package apu_pkg;

	// Register map of the pulse channel
	localparam logic [1:0] REG_CTRL  = 2'd0;
	localparam logic [1:0] REG_SWEEP = 2'd1;
	localparam logic [1:0] REG_TLO   = 2'd2;
	localparam logic [1:0] REG_THI   = 2'd3;

	localparam int PERIOD_W = 11;
	localparam int VOL_W    = 4;

	// Bit n is the gate value at sequencer step n
	localparam logic [7:0] DUTY_TABLE [4] = '{
		8'b1000_0000,
		8'b1100_0000,
		8'b1111_0000,
		8'b0011_1111
	};

	// Length counter load values, indexed by the 5-bit field of REG_THI
	localparam logic [7:0] LENGTH_TABLE [32] = '{
		8'd10,  8'd254,
		8'd20,  8'd2,
		8'd40,  8'd4,
		8'd80,  8'd6,
		8'd160, 8'd8,
		8'd60,  8'd10,
		8'd14,  8'd12,
		8'd26,  8'd14,
		8'd12,  8'd16,
		8'd24,  8'd18,
		8'd48,  8'd20,
		8'd96,  8'd22,
		8'd192, 8'd24,
		8'd72,  8'd26,
		8'd16,  8'd28,
		8'd32,  8'd30
	};

	// Shorter periods are above the audible range
	localparam logic [PERIOD_W-1:0] MIN_PERIOD = 11'd8;

	typedef enum logic [1:0] {
		ENV_IDLE,
		ENV_START,
		ENV_RUN
	} env_state_e;

endpackage

/* verilog/pulse_reg_port.sv */
`timescale 1ns/1ns

module pulse_reg_port import apu_pkg::*; (
	input  logic                timer_clk,
	input  logic                n_reset,
	input  logic                wr_en,
	input  logic [1:0]          wr_addr,
	input  logic [7:0]          wr_data,
	output logic [1:0]          duty,
	output logic                lc_halt,
	output logic                const_vol,
	output logic [VOL_W-1:0]    vol,
	output logic                swp_en,
	output logic [2:0]          swp_period,
	output logic                swp_neg,
	output logic [2:0]          swp_shift,
	output logic [PERIOD_W-1:0] timer_load_period,
	output logic [4:0]          lc_index,
	output logic                hi_write,
	output logic                sweep_write
);

	logic [7:0] reg_ctrl;
	logic [7:0] reg_sweep;
	logic [7:0] reg_tlo;
	logic [7:0] reg_thi;

	always_ff @(posedge timer_clk, negedge n_reset) begin
		if (!n_reset) begin
			reg_ctrl    <= 8'h00;
			reg_sweep   <= 8'h00;
			reg_tlo     <= 8'h00;
			reg_thi     <= 8'h00;
			hi_write    <= 1'b0;
			sweep_write <= 1'b0;
		end else begin
			hi_write    <= wr_en && wr_addr == REG_THI;
			sweep_write <= wr_en && wr_addr == REG_SWEEP;
			if (wr_en) begin
				case (wr_addr)
					REG_CTRL:  reg_ctrl  <= wr_data;
					REG_SWEEP: reg_sweep <= wr_data;
					REG_TLO:   reg_tlo   <= wr_data;
					REG_THI:   reg_thi   <= wr_data;
					default:   reg_ctrl  <= reg_ctrl;
				endcase
			end
		end
	end

	// Duty and envelope
	assign duty      = reg_ctrl[7:6];
	assign lc_halt   = reg_ctrl[5];
	assign const_vol = reg_ctrl[4];
	assign vol       = reg_ctrl[3:0];

	assign swp_en     = reg_sweep[7];
	assign swp_period = reg_sweep[6:4];
	assign swp_neg    = reg_sweep[3];
	assign swp_shift  = reg_sweep[2:0];

	// Timer period spans the low byte and three bits of the high byte
	assign timer_load_period = {reg_thi[2:0], reg_tlo};
	assign lc_index          = reg_thi[7:3];

endmodule

/* verilog/pulse_envelope.sv */
`timescale 1ns/1ns

module pulse_envelope import apu_pkg::*; (
	input  logic             timer_clk,
	input  logic             n_reset,
	input  logic             qframe,
	input  logic             hi_write,
	input  logic             loop,
	input  logic             const_vol,
	input  logic [VOL_W-1:0] vol,
	output logic [VOL_W-1:0] env_level
);

	env_state_e       state;
	logic [VOL_W-1:0] divider;
	logic [VOL_W-1:0] decay;

	always_ff @(posedge timer_clk, negedge n_reset) begin
		if (!n_reset) begin
			state   <= ENV_IDLE;
			divider <= '0;
			decay   <= '0;
		end else if (hi_write) begin
			// Restart waits for the next quarter frame
			state <= ENV_START;
		end else if (qframe) begin
			case (state)
				ENV_START: begin
					state   <= ENV_RUN;
					decay   <= '1;
					divider <= vol;
				end
				ENV_RUN: begin
					if (divider == '0) begin
						divider <= vol;
						if (decay != '0)
							decay <= decay - 1'b1;
						else if (loop)
							decay <= '1;
					end else begin
						divider <= divider - 1'b1;
					end
				end
				default: begin
					// Not started yet, decay stays silent
					state <= ENV_IDLE;
				end
			endcase
		end
	end

	assign env_level = const_vol ? vol : decay;

endmodule

/* verilog/pulse_sweep.sv */
`timescale 1ns/1ns

module pulse_sweep import apu_pkg::*; #(
	parameter logic ones_comp = 1'b0
) (
	input  logic                timer_clk,
	input  logic                n_reset,
	input  logic                hframe,
	input  logic                hi_write,
	input  logic                sweep_write,
	input  logic [PERIOD_W-1:0] timer_load_period,
	input  logic                swp_en,
	input  logic [2:0]          swp_period,
	input  logic                swp_neg,
	input  logic [2:0]          swp_shift,
	output logic [PERIOD_W-1:0] period,
	output logic                sweep_mute
);

	logic [PERIOD_W-1:0] shifted;
	logic [PERIOD_W-1:0] target;
	logic                carry;
	logic                ovf;
	logic                apply;
	logic [2:0]          divider;
	logic                reload;

	// Negate mode adds the inverted shift, plus one on the two's complement variant
	assign shifted = period >> swp_shift;
	assign {carry, target} = {1'b0, period}
		+ {1'b0, shifted ^ {PERIOD_W{swp_neg}}}
		+ {{PERIOD_W{1'b0}}, swp_neg & ~ones_comp};

	// Missing carry on a subtract is an underflow
	assign ovf        = swp_neg ^ carry;
	assign sweep_mute = ~swp_neg & carry;

	assign apply = swp_en && divider == 3'd0 && swp_shift != 3'd0 && !ovf;

	always_ff @(posedge timer_clk, negedge n_reset) begin
		if (!n_reset) begin
			period <= '0;
		end else if (hi_write) begin
			period <= timer_load_period;
		end else if (hframe && apply) begin
			period <= target;
		end
	end

	always_ff @(posedge timer_clk, negedge n_reset) begin
		if (!n_reset) begin
			divider <= 3'd0;
			reload  <= 1'b0;
		end else begin
			if (hframe) begin
				if (divider == 3'd0 || reload)
					divider <= swp_period;
				else
					divider <= divider - 3'd1;
			end
			// A register write during the frame strobe keeps the flag
			if (sweep_write)
				reload <= 1'b1;
			else if (hframe)
				reload <= 1'b0;
		end
	end

endmodule

/* verilog/pulse_sequencer.sv */
`timescale 1ns/1ns

module pulse_sequencer import apu_pkg::*; (
	input  logic                timer_clk,
	input  logic                n_reset,
	input  logic [PERIOD_W-1:0] period,
	input  logic                hi_write,
	input  logic [1:0]          duty,
	output logic                step_pulse,
	output logic                wave_bit
);

	logic                tick;
	logic [PERIOD_W-1:0] timer_cnt;
	logic [2:0]          step;
	logic                expire;

	// APU tick at half the clock rate
	always_ff @(posedge timer_clk, negedge n_reset) begin
		if (!n_reset)
			tick <= 1'b0;
		else
			tick <= ~tick;
	end

	assign expire = tick && timer_cnt == '0;

	always_ff @(posedge timer_clk, negedge n_reset) begin
		if (!n_reset) begin
			timer_cnt <= '0;
		end else if (tick) begin
			if (timer_cnt == '0)
				timer_cnt <= period;
			else
				timer_cnt <= timer_cnt - 1'b1;
		end
	end

	// Step counts down and wraps from 0 to 7
	always_ff @(posedge timer_clk, negedge n_reset) begin
		if (!n_reset) begin
			step <= 3'd0;
		end else if (hi_write) begin
			step <= 3'd0;
		end else if (expire) begin
			step <= step - 3'd1;
		end
	end

	assign step_pulse = expire;
	assign wave_bit   = DUTY_TABLE[duty][step];

endmodule

/* verilog/pulse_length_counter.sv */
`timescale 1ns/1ns

module pulse_length_counter import apu_pkg::*; (
	input  logic       timer_clk,
	input  logic       n_reset,
	input  logic       hframe,
	input  logic       hi_write,
	input  logic [4:0] lc_index,
	input  logic       halt,
	output logic       lc_gate
);

	logic [7:0] count;
	logic [7:0] load_value;
	logic       count_down;

	assign load_value = LENGTH_TABLE[lc_index];

	// Halt freezes the count, it does not clear it
	assign count_down = hframe && !halt && count != 8'd0;

	always_ff @(posedge timer_clk, negedge n_reset) begin
		if (!n_reset) begin
			count <= 8'd0;
		end else if (hi_write) begin
			count <= load_value;
		end else if (count_down) begin
			count <= count - 8'd1;
		end
	end

	assign lc_gate = count != 8'd0;

endmodule

/* verilog/pulse_sample_out.sv */
`timescale 1ns/1ns

module pulse_sample_out import apu_pkg::*; (
	input  logic                timer_clk,
	input  logic                n_reset,
	input  logic                step_pulse,
	input  logic                wave_bit,
	input  logic [VOL_W-1:0]    env_level,
	input  logic                lc_gate,
	input  logic [PERIOD_W-1:0] period,
	input  logic                sweep_mute,
	input  logic                sample_ready,
	output logic [VOL_W-1:0]    sample,
	output logic                sample_valid
);

	logic             gate;
	logic [VOL_W-1:0] level;
	logic             capture;

	// Any one of the four sources silences the channel
	assign gate  = wave_bit && lc_gate && period >= MIN_PERIOD && !sweep_mute;
	assign level = gate ? env_level : '0;

	// Step pulses arriving under back-pressure are lost
	assign capture = step_pulse && (!sample_valid || sample_ready);

	always_ff @(posedge timer_clk, negedge n_reset) begin
		if (!n_reset)
			sample_valid <= 1'b0;
		else if (capture)
			sample_valid <= 1'b1;
		else if (sample_ready)
			sample_valid <= 1'b0;
	end

	always_ff @(posedge timer_clk) begin
		if (capture)
			sample <= level;
	end

endmodule

/* verilog/pulse_channel.sv */
`timescale 1ns/1ns

module pulse_channel import apu_pkg::*; #(
	parameter logic ones_comp = 1'b0
) (
	input  logic             timer_clk,
	input  logic             n_reset,
	input  logic             wr_en,
	input  logic [1:0]       wr_addr,
	input  logic [7:0]       wr_data,
	input  logic             qframe,
	input  logic             hframe,
	output logic [VOL_W-1:0] sample,
	output logic             sample_valid,
	input  logic             sample_ready,
	output logic             active
);

	logic [1:0]          duty;
	logic                lc_halt;
	logic                const_vol;
	logic [VOL_W-1:0]    vol;
	logic                swp_en;
	logic [2:0]          swp_period;
	logic                swp_neg;
	logic [2:0]          swp_shift;
	logic [PERIOD_W-1:0] timer_load_period;
	logic [4:0]          lc_index;
	logic                hi_write;
	logic                sweep_write;
	logic [PERIOD_W-1:0] period;
	logic                sweep_mute;
	logic                step_pulse;
	logic                wave_bit;
	logic [VOL_W-1:0]    env_level;
	logic                lc_gate;

	pulse_reg_port u_reg_port (.*);

	// Length halt doubles as envelope loop
	pulse_envelope u_envelope (
		.loop(lc_halt),
		.*
	);

	pulse_sweep #(.ones_comp(ones_comp)) u_sweep (.*);

	pulse_sequencer u_sequencer (.*);

	pulse_length_counter u_length (
		.halt(lc_halt),
		.*
	);

	pulse_sample_out u_sample_out (.*);

	assign active = lc_gate;

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
	output logic timer_clk,
	output logic n_reset
);

	localparam int HALF_PERIOD = 20;
	localparam int RESET_CYCLES = 8;

	initial begin
		timer_clk = 1'b0;
		forever #HALF_PERIOD timer_clk = ~timer_clk;
	end

	initial begin
		n_reset = 1'b0;
		repeat (RESET_CYCLES) @(posedge timer_clk);
		@(negedge timer_clk);
		n_reset = 1'b1;
	end

endmodule

/* sim/pulse_checker.sv */
`timescale 1ns/1ns

module pulse_checker import apu_pkg::*; (
	input logic       timer_clk,
	input logic       n_reset,
	input logic       wr_en,
	input logic [1:0] wr_addr,
	input logic [7:0] wr_data,
	input logic       qframe,
	input logic       hframe,
	input logic [3:0] sample,
	input logic       sample_valid,
	input logic       sample_ready,
	input logic       active
);

	int errors = 0;
	int samples = 0;

	// Model of the channel state
	logic [7:0]  m_ctrl, m_sweep, m_tlo, m_thi;
	logic        m_hi_w, m_sw_w;
	logic        m_tick;
	logic [10:0] m_timer, m_period;
	logic [2:0]  m_step, m_swp_div;
	logic        m_reload;
	logic [1:0]  m_env_state;
	logic [3:0]  m_env_div, m_decay;
	logic [7:0]  m_len;
	logic        m_valid;
	logic [3:0]  m_sample;

	logic        expire;
	logic        capture;
	logic [3:0]  level;
	logic [10:0] shifted;
	logic [11:0] sweep_sum;
	logic        sweep_ok;

	function automatic logic [3:0] expected_sample(input logic [1:0] duty, input logic [2:0] step,
			input logic [3:0] lvl, input logic [7:0] length, input logic [10:0] period,
			input logic neg, input logic [2:0] shift);
		logic [11:0] sum;
		logic        gate;
		sum = {1'b0, period} + {1'b0, period >> shift};
		gate = DUTY_TABLE[duty][step] && length != 8'd0 && period >= 11'd8
			&& (neg || !sum[11]);
		return gate ? lvl : 4'd0;
	endfunction

	assign expire    = m_tick && m_timer == 11'd0;
	assign capture   = expire && (!m_valid || sample_ready);
	assign level     = m_ctrl[4] ? m_ctrl[3:0] : m_decay;
	assign shifted   = m_period >> m_sweep[2:0];
	assign sweep_sum = m_sweep[3] ? {1'b0, m_period - shifted} : {1'b0, m_period} + shifted;
	// Positive sweep may not overflow; negative never underflows
	assign sweep_ok  = m_sweep[7] && m_swp_div == 3'd0 && m_sweep[2:0] != 3'd0
		&& !sweep_sum[11];

	always @(posedge timer_clk or negedge n_reset) begin
		if (!n_reset) begin
			{m_ctrl, m_sweep, m_tlo, m_thi} <= '0;
			{m_hi_w, m_sw_w, m_tick, m_reload, m_valid} <= '0;
			{m_timer, m_period, m_step, m_swp_div} <= '0;
			{m_env_state, m_env_div, m_decay, m_len} <= '0;
		end else begin
			if (active !== (m_len != 8'd0)) begin
				errors++;
				$display("FAIL %0t: active expected %0b got %0b", $time, m_len != 0, active);
			end
			if (sample_valid !== m_valid) begin
				errors++;
				$display("FAIL %0t: valid expected %0b got %0b", $time, m_valid, sample_valid);
			end else if (m_valid && sample !== m_sample) begin
				errors++;
				$display("FAIL %0t: sample expected %0d got %0d", $time, m_sample, sample);
			end
			if (sample_valid && sample_ready)
				samples++;

			if (wr_en) begin
				case (wr_addr)
					2'd0: m_ctrl <= wr_data;
					2'd1: m_sweep <= wr_data;
					2'd2: m_tlo <= wr_data;
					default: m_thi <= wr_data;
				endcase
			end
			m_hi_w <= wr_en && wr_addr == 2'd3;
			m_sw_w <= wr_en && wr_addr == 2'd1;

			m_tick <= ~m_tick;
			if (m_tick)
				m_timer <= (m_timer == 11'd0) ? m_period : m_timer - 11'd1;
			if (m_hi_w)
				m_step <= 3'd0;
			else if (expire)
				m_step <= m_step - 3'd1;

			if (m_hi_w)
				m_period <= {m_thi[2:0], m_tlo};
			else if (hframe && sweep_ok)
				m_period <= sweep_sum[10:0];
			if (hframe)
				m_swp_div <= (m_swp_div == 3'd0 || m_reload) ? m_sweep[6:4] : m_swp_div - 3'd1;
			if (m_sw_w)
				m_reload <= 1'b1;
			else if (hframe)
				m_reload <= 1'b0;

			// Envelope state 0 is idle, 1 is start pending and 2 is running
			if (m_hi_w) begin
				m_env_state <= 2'd1;
			end else if (qframe && m_env_state == 2'd1) begin
				m_env_state <= 2'd2;
				m_decay <= 4'd15;
				m_env_div <= m_ctrl[3:0];
			end else if (qframe && m_env_state == 2'd2) begin
				if (m_env_div != 4'd0)
					m_env_div <= m_env_div - 4'd1;
				else begin
					m_env_div <= m_ctrl[3:0];
					if (m_decay != 4'd0)
						m_decay <= m_decay - 4'd1;
					else if (m_ctrl[5])
						m_decay <= 4'd15;
				end
			end

			if (m_hi_w)
				m_len <= LENGTH_TABLE[m_thi[7:3]];
			else if (hframe && !m_ctrl[5] && m_len != 8'd0)
				m_len <= m_len - 8'd1;

			if (capture) begin
				m_valid <= 1'b1;
				m_sample <= expected_sample(m_ctrl[7:6], m_step, level, m_len, m_period,
					m_sweep[3], m_sweep[2:0]);
			end else if (sample_ready) begin
				m_valid <= 1'b0;
			end
		end
	end

endmodule

/* sim/pulse_tb.sv */
`timescale 1ns/1ns

module pulse_tb;

	localparam int CLK_PERIOD = 40;
	localparam logic [31:0] SEED = 32'hf807f1e2;
	localparam int TEST_CYCLES = 45000;

	logic       timer_clk;
	logic       n_reset;
	logic       wr_en = 1'b0;
	logic [1:0] wr_addr = 2'd0;
	logic [7:0] wr_data = 8'd0;
	logic       qframe = 1'b0;
	logic       hframe = 1'b0;
	logic       sample_ready = 1'b1;
	logic [3:0] sample;
	logic       sample_valid;
	logic       active;
	logic       random_ready = 1'b0;
	int         transfers = 0;
	int         frame_cnt = 0;

	tb_clock u_clock (.timer_clk(timer_clk), .n_reset(n_reset));

	pulse_channel dut (.*);

	pulse_checker u_checker (.*);

	task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
		@(negedge timer_clk);
		wr_en = 1'b1;
		wr_addr = addr;
		wr_data = data;
		@(negedge timer_clk);
		wr_en = 1'b0;
	endtask

	// The REG_THI write goes last because it loads the period
	task automatic setup_channel(input logic [7:0] ctrl, input logic [7:0] swp,
			input logic [10:0] period, input logic [4:0] len_idx);
		write_reg(2'd0, ctrl);
		write_reg(2'd1, swp);
		write_reg(2'd2, period[7:0]);
		write_reg(2'd3, {len_idx, period[10:8]});
	endtask

	task automatic wait_samples(input int n);
		int target;
		target = transfers + n;
		wait (transfers >= target);
	endtask

	always @(posedge timer_clk)
		if (sample_valid && sample_ready)
			transfers++;

	// Quarter frame every 64 cycles, half frame on every second one
	initial begin
		void'($urandom(SEED));
		forever begin
			@(negedge timer_clk);
			if (n_reset) begin
				frame_cnt++;
				qframe = (frame_cnt % 64) == 0;
				hframe = (frame_cnt % 128) == 0;
			end
			// Sparse ready lets step pulses arrive under back-pressure
			sample_ready = random_ready ? (($urandom % 16) == 0) : 1'b1;
		end
	end

	initial begin
		wait (n_reset);
		for (int d = 0; d < 4; d++) begin
			setup_channel({d[1:0], 6'b11_1001}, 8'h00, 11'd20, 5'd1);
			wait_samples(16);
		end
		setup_channel(8'b1000_0001, 8'h00, 11'd20, 5'd1);
		wait_samples(100);
		setup_channel(8'b1010_0000, 8'h00, 11'd20, 5'd1);
		wait_samples(60);
		setup_channel(8'b1001_1001, 8'h00, 11'd20, 5'd3);
		wait_samples(20);
		setup_channel(8'b1011_1001, 8'h00, 11'd20, 5'd3);
		wait_samples(20);
		setup_channel(8'b1011_1001, 8'b1001_0010, 11'd40, 5'd1);
		wait_samples(16);
		setup_channel(8'b1011_1001, 8'b0000_0001, 11'd1400, 5'd1);
		wait_samples(3);
		setup_channel(8'b1011_1001, 8'h00, 11'd5, 5'd1);
		wait_samples(4);
		random_ready = 1'b1;
		setup_channel(8'b0110_0000, 8'h00, 11'd10, 5'd1);
		wait_samples(100);
		random_ready = 1'b0;
		repeat (10) @(negedge timer_clk);
		$display("errors=%0d samples=%0d", u_checker.errors, u_checker.samples);
		if (u_checker.errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin
		#((TEST_CYCLES * 2 + 1000) * CLK_PERIOD);
		$display("Timeout: the tests did not finish in time");
		$display("errors=%0d samples=%0d", u_checker.errors, u_checker.samples);
		$display("Simulation failed");
		$finish;
	end

endmodule

/* all.f */
verilog/apu_pkg.sv
verilog/pulse_reg_port.sv
verilog/pulse_envelope.sv
verilog/pulse_sweep.sv
verilog/pulse_sequencer.sv
verilog/pulse_length_counter.sv
verilog/pulse_sample_out.sv
verilog/pulse_channel.sv
sim/tb_clock.sv
sim/pulse_checker.sv
sim/pulse_tb.sv
